//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int IMM_W     = 16;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [IMM_W-1:0]     imm_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SWL,
        MEM_SWR
    } mem_op_e;

    // sa is imm[10:6], zero-extended
    typedef enum logic [1:0] {
        SRC1_RS,
        SRC1_SA,
        SRC1_PC
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT,
        SRC2_IMM_SEXT,
        SRC2_IMM_ZEXT,
        SRC2_EIGHT
    } src2_sel_e;

    typedef enum logic [4:0] {
        EXC_NONE     = 5'h1f,
        EXC_ADEL     = 5'h04,
        EXC_ADES     = 5'h05,
        EXC_OVERFLOW = 5'h0c
    } exc_code_e;

endpackage

`default_nettype wire

//--- hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int NUM_LANES = 4;

    typedef logic [1:0]           byte_off_t;
    typedef logic [NUM_LANES-1:0] strobe_t;
    typedef logic [7:0]           byte_t;

    // accepted means addr_ok seen, instruction still in stage
    typedef enum logic {
        REQ_IDLE,
        REQ_ACCEPTED
    } req_state_e;

endpackage

`default_nettype wire

//--- hw/exe_op_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exe_op_if import isa_pkg::*; ();

    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    word_t     rs_value;
    word_t     rt_value;
    imm_t      imm;
    word_t     pc;
    reg_idx_t  dest;
    mem_op_e   mem_op;
    logic      of_check;

    modport stage (
        output alu_op, src1_sel, src2_sel,
        output rs_value, rt_value, imm, pc,
        output dest, mem_op, of_check
    );

    modport exe (
        input alu_op, src1_sel, src2_sel,
        input rs_value, rt_value, imm, pc,
        input dest, mem_op, of_check
    );

endinterface

`default_nettype wire

//--- hw/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import isa_pkg::*, bus_pkg::*; ();

    word_t     addr;
    mem_op_e   mem_op;
    byte_off_t byte_off;
    word_t     rt_value;
    logic      is_load;
    logic      is_store;
    // any exception code other than none
    logic      exc;

    modport producer (
        output addr, mem_op, byte_off, rt_value,
        output is_load, is_store, exc
    );

    modport lane (
        input mem_op, byte_off, rt_value
    );

    modport request (
        input addr, is_load, is_store, exc
    );

endinterface

`default_nettype wire

//--- hw/stage_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl import isa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  alu_op_e   in_alu_op,
    input  src1_sel_e in_src1_sel,
    input  src2_sel_e in_src2_sel,
    input  word_t     in_rs_value,
    input  word_t     in_rt_value,
    input  word_t     in_pc,
    input  imm_t      in_imm,
    input  reg_idx_t  in_dest,
    input  mem_op_e   in_mem_op,
    input  logic      in_of_check,
    input  logic      ready_go,
    input  logic      next_allowin,
    output logic      allowin,
    output logic      valid,
    exe_op_if.stage   op
);

    logic load;

    // empty, or the current instruction leaves this cycle
    assign allowin = !valid || (ready_go && next_allowin);
    assign load    = in_valid && allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    // these two steer requests and exceptions
    always_ff @(posedge clk) begin
        if (reset) begin
            op.mem_op   <= MEM_NONE;
            op.of_check <= 1'b0;
        end else if (load) begin
            op.mem_op   <= in_mem_op;
            op.of_check <= in_of_check;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op.alu_op   <= in_alu_op;
            op.src1_sel <= in_src1_sel;
            op.src2_sel <= in_src2_sel;
            op.rs_value <= in_rs_value;
            op.rt_value <= in_rt_value;
            op.pc       <= in_pc;
            op.imm      <= in_imm;
            op.dest     <= in_dest;
        end
    end

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import isa_pkg::*; (
    exe_op_if.exe       op,
    output word_t       result,
    output exc_code_e   exc_code,
    output word_t       bad_vaddr,
    mem_req_if.producer mem
);

    word_t src1;
    word_t src2;
    word_t alu_result;
    logic  sign1;
    logic  sign2;
    logic  sign_r;
    logic  overflow;
    logic  is_load;
    logic  is_store;
    logic  adel;
    logic  ades;

    always_comb begin
        case (op.src1_sel)
            SRC1_SA: src1 = word_t'(op.imm[10:6]);
            SRC1_PC: src1 = op.pc;
            default: src1 = op.rs_value;
        endcase
    end

    always_comb begin
        case (op.src2_sel)
            SRC2_IMM_SEXT: src2 = {{(WORD_W-IMM_W){op.imm[IMM_W-1]}}, op.imm};
            SRC2_IMM_ZEXT: src2 = {{(WORD_W-IMM_W){1'b0}}, op.imm};
            SRC2_EIGHT:    src2 = word_t'(8);
            default:       src2 = op.rt_value;
        endcase
    end

    // shifts take the amount from src1 and the value from src2
    always_comb begin
        case (op.alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = word_t'($signed(src1) < $signed(src2));
            ALU_SLTU: alu_result = word_t'(src1 < src2);
            ALU_AND:  alu_result = src1 & src2;
            ALU_OR:   alu_result = src1 | src2;
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_SLL:  alu_result = src2 << src1[4:0];
            ALU_SRL:  alu_result = src2 >> src1[4:0];
            ALU_SRA:  alu_result = word_t'($signed(src2) >>> src1[4:0]);
            ALU_LUI:  alu_result = {src2[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
            default:  alu_result = '0;
        endcase
    end

    assign sign1  = src1[WORD_W-1];
    assign sign2  = src2[WORD_W-1];
    assign sign_r = alu_result[WORD_W-1];

    assign overflow = op.of_check &&
                      ((op.alu_op == ALU_ADD && sign1 == sign2 && sign_r != sign1) ||
                       (op.alu_op == ALU_SUB && sign1 != sign2 && sign_r != sign1));

    assign is_load  = op.mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
    assign is_store = op.mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};

    // byte, swl and swr accesses never misalign
    assign adel = ((op.mem_op inside {MEM_LH, MEM_LHU}) && alu_result[0]) ||
                  (op.mem_op == MEM_LW && alu_result[1:0] != 2'b00);
    assign ades = (op.mem_op == MEM_SH && alu_result[0]) ||
                  (op.mem_op == MEM_SW && alu_result[1:0] != 2'b00);

    always_comb begin
        if (overflow) begin
            exc_code = EXC_OVERFLOW;
        end else if (adel) begin
            exc_code = EXC_ADEL;
        end else if (ades) begin
            exc_code = EXC_ADES;
        end else begin
            exc_code = EXC_NONE;
        end
    end

    assign bad_vaddr = (exc_code inside {EXC_ADEL, EXC_ADES}) ? alu_result : '0;
    assign result    = alu_result;

    assign mem.addr     = alu_result;
    assign mem.mem_op   = op.mem_op;
    assign mem.byte_off = alu_result[1:0];
    assign mem.rt_value = op.rt_value;
    assign mem.is_load  = is_load;
    assign mem.is_store = is_store;
    assign mem.exc      = exc_code != EXC_NONE;

endmodule

`default_nettype wire

//--- hw/store_lane.sv
`timescale 1ns/1ps
`default_nettype none

module store_lane import isa_pkg::*, bus_pkg::*; #(
    parameter int LANE = 0
) (
    input  mem_op_e   mem_op,
    input  byte_off_t byte_off,
    input  word_t     rt_value,
    output logic      strobe,
    output byte_t     data
);

    int        off;
    byte_off_t sel;

    assign off = int'(byte_off);

    always_comb begin
        case (mem_op)
            MEM_SB:  strobe = (LANE == off);
            MEM_SH:  strobe = (LANE == off) || (LANE == off + 1);
            MEM_SW:  strobe = 1'b1;
            MEM_SWL: strobe = (LANE <= off);
            MEM_SWR: strobe = (LANE >= off);
            default: strobe = 1'b0;
        endcase
    end

    // rt byte that feeds this lane
    always_comb begin
        sel = byte_off_t'(LANE);
        if (strobe) begin
            case (mem_op)
                MEM_SB:  sel = 2'd0;
                MEM_SH:  sel = byte_off_t'(LANE % 2);
                MEM_SWL: sel = byte_off_t'(3 - off + LANE);
                MEM_SWR: sel = byte_off_t'(LANE - off);
                default: sel = byte_off_t'(LANE);
            endcase
        end
    end

    assign data = rt_value[8*sel +: 8];

endmodule

`default_nettype wire

//--- hw/mem_request.sv
`timescale 1ns/1ps
`default_nettype none

module mem_request import isa_pkg::*, bus_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      valid,
    input  logic      next_allowin,
    mem_req_if.request mem,
    input  logic      lane_strobe [NUM_LANES],
    input  byte_t     lane_data [NUM_LANES],
    input  logic      data_sram_addr_ok,
    output logic      data_sram_en,
    output logic      data_sram_wr,
    output strobe_t   data_sram_wstrb,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    output logic      ready_go
);

    req_state_e state;
    logic       needs_req;
    logic       accepted_now;
    logic       leaving;

    assign needs_req    = valid && (mem.is_load || mem.is_store) && !mem.exc;
    assign data_sram_en = needs_req && state == REQ_IDLE;
    assign accepted_now = data_sram_en && data_sram_addr_ok;

    // non-memory and faulting instructions go at once
    assign ready_go = !needs_req || state == REQ_ACCEPTED || accepted_now;
    assign leaving  = valid && ready_go && next_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= REQ_IDLE;
        end else if (leaving) begin
            state <= REQ_IDLE;
        end else if (accepted_now) begin
            // held by the next stage so the request is not repeated
            state <= REQ_ACCEPTED;
        end
    end

    assign data_sram_wr   = mem.is_store;
    assign data_sram_addr = mem.addr;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            data_sram_wstrb[i]        = lane_strobe[i] && mem.is_store;
            data_sram_wdata[8*i +: 8] = lane_data[i];
        end
    end

endmodule

`default_nettype wire

//--- hw/exe_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_top import isa_pkg::*, bus_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    input  alu_op_e   in_alu_op,
    input  src1_sel_e in_src1_sel,
    input  src2_sel_e in_src2_sel,
    input  word_t     in_rs_value,
    input  word_t     in_rt_value,
    input  word_t     in_pc,
    input  imm_t      in_imm,
    input  reg_idx_t  in_dest,
    input  mem_op_e   in_mem_op,
    input  logic      in_of_check,
    input  logic      next_allowin,
    output logic      allowin,
    input  logic      data_sram_addr_ok,
    output logic      data_sram_en,
    output logic      data_sram_wr,
    output strobe_t   data_sram_wstrb,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    output logic      out_valid,
    output word_t     out_result,
    output reg_idx_t  out_dest,
    output mem_op_e   out_mem_op,
    output exc_code_e out_exc_code,
    output word_t     out_bad_vaddr
);

    exe_op_if  op_bus ();
    mem_req_if mem_bus ();

    logic  valid;
    logic  ready_go;
    logic  lane_strobe [NUM_LANES];
    byte_t lane_data [NUM_LANES];

    stage_ctrl u_stage_ctrl (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_alu_op    (in_alu_op),
        .in_src1_sel  (in_src1_sel),
        .in_src2_sel  (in_src2_sel),
        .in_rs_value  (in_rs_value),
        .in_rt_value  (in_rt_value),
        .in_pc        (in_pc),
        .in_imm       (in_imm),
        .in_dest      (in_dest),
        .in_mem_op    (in_mem_op),
        .in_of_check  (in_of_check),
        .ready_go     (ready_go),
        .next_allowin (next_allowin),
        .allowin      (allowin),
        .valid        (valid),
        .op           (op_bus.stage)
    );

    execute_unit u_execute_unit (
        .op        (op_bus.exe),
        .result    (out_result),
        .exc_code  (out_exc_code),
        .bad_vaddr (out_bad_vaddr),
        .mem       (mem_bus.producer)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        store_lane #(.LANE(i)) u_store_lane (
            .mem_op   (mem_bus.mem_op),
            .byte_off (mem_bus.byte_off),
            .rt_value (mem_bus.rt_value),
            .strobe   (lane_strobe[i]),
            .data     (lane_data[i])
        );
    end

    mem_request u_mem_request (
        .clk               (clk),
        .reset             (reset),
        .valid             (valid),
        .next_allowin      (next_allowin),
        .mem               (mem_bus.request),
        .lane_strobe       (lane_strobe),
        .lane_data         (lane_data),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram_en      (data_sram_en),
        .data_sram_wr      (data_sram_wr),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .ready_go          (ready_go)
    );

    assign out_valid  = valid && ready_go;
    assign out_dest   = op_bus.dest;
    assign out_mem_op = op_bus.mem_op;

endmodule

`default_nettype wire

//--- verification/exe_stage_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_asserts import isa_pkg::*, bus_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      next_allowin,
    input logic      out_valid,
    input word_t     out_result,
    input exc_code_e out_exc_code,
    input logic      data_sram_en,
    input logic      data_sram_wr,
    input strobe_t   data_sram_wstrb
);

    int fail_count = 0;

    quiet_after_reset: assert property (@(posedge clk) reset |=> !out_valid && !data_sram_en)
        else begin
            fail_count++;
            $error("out_valid or data_sram_en high in the cycle after reset");
        end

    // a faulting access never reaches the SRAM
    no_req_on_exc: assert property (@(posedge clk) disable iff (reset)
        data_sram_en |-> out_exc_code == EXC_NONE)
        else begin
            fail_count++;
            $error("data_sram_en high together with an exception");
        end

    no_strobe_on_read: assert property (@(posedge clk) disable iff (reset)
        !data_sram_wr |-> data_sram_wstrb == '0)
        else begin
            fail_count++;
            $error("data_sram_wstrb not zero while data_sram_wr is low");
        end

    result_held: assert property (@(posedge clk) disable iff (reset)
        out_valid && !next_allowin |=> $stable(out_result))
        else begin
            fail_count++;
            $error("out_result changed while stalled by next stage");
        end

endmodule

bind exe_stage_top exe_stage_asserts u_asserts (.*);

`default_nettype wire

//--- verification/exe_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb import isa_pkg::*, bus_pkg::*; ();

    // about four times the length of all tests together
    localparam int MAX_CYCLES = 2000;

    logic      clk;
    logic      reset;
    logic      in_valid;
    alu_op_e   in_alu_op;
    src1_sel_e in_src1_sel;
    src2_sel_e in_src2_sel;
    word_t     in_rs_value;
    word_t     in_rt_value;
    word_t     in_pc;
    imm_t      in_imm;
    reg_idx_t  in_dest;
    mem_op_e   in_mem_op;
    logic      in_of_check;
    logic      next_allowin;
    logic      allowin;
    logic      data_sram_addr_ok;
    logic      data_sram_en;
    logic      data_sram_wr;
    strobe_t   data_sram_wstrb;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    logic      out_valid;
    word_t     out_result;
    reg_idx_t  out_dest;
    mem_op_e   out_mem_op;
    exc_code_e out_exc_code;
    word_t     out_bad_vaddr;

    // expected response of the instruction in the stage
    word_t     exp_result;
    word_t     exp_bad;
    word_t     exp_wdata;
    exc_code_e exp_exc;
    strobe_t   exp_wstrb;
    logic      exp_req;
    logic      exp_store;

    word_t lcg_state = 32'h786f85b9;
    int    cycle_count = 0;
    int    accept_count = 0;

    exe_stage_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && data_sram_en && data_sram_addr_ok) begin
            accept_count <= accept_count + 1;
        end
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_strobe(input string name, input strobe_t got, input strobe_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_mem_op(input string name, input mem_op_e got, input mem_op_e exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // shifts move src2 by src1[4:0] and lui takes the low half of src2
    function automatic word_t model_alu(input alu_op_e a, input word_t x, input word_t y);
        case (a)
            ALU_ADD:  return x + y;
            ALU_SUB:  return x - y;
            ALU_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (x < y) ? 32'd1 : 32'd0;
            ALU_AND:  return x & y;
            ALU_OR:   return x | y;
            ALU_XOR:  return x ^ y;
            ALU_NOR:  return ~(x | y);
            ALU_SLL:  return y << x[4:0];
            ALU_SRL:  return y >> x[4:0];
            ALU_SRA:  return word_t'($signed(y) >>> x[4:0]);
            ALU_LUI:  return {y[15:0], 16'h0000};
            default:  return '0;
        endcase
    endfunction

    task automatic predict();
        word_t x;
        word_t y;
        int    off;
        int    src;
        int    k;
        logic  is_ld;
        case (in_src1_sel)
            SRC1_SA: x = {27'd0, in_imm[10:6]};
            SRC1_PC: x = in_pc;
            default: x = in_rs_value;
        endcase
        case (in_src2_sel)
            SRC2_IMM_SEXT: y = {{16{in_imm[15]}}, in_imm};
            SRC2_IMM_ZEXT: y = {16'h0000, in_imm};
            SRC2_EIGHT:    y = 32'd8;
            default:       y = in_rt_value;
        endcase
        exp_result = model_alu(in_alu_op, x, y);
        off = int'(exp_result[1:0]);
        is_ld = in_mem_op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
        exp_store = in_mem_op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
        exp_exc = EXC_NONE;
        if (in_of_check && in_alu_op == ALU_ADD && x[31] == y[31] && exp_result[31] != x[31]) begin
            exp_exc = EXC_OVERFLOW;
        end else if (in_of_check && in_alu_op == ALU_SUB && x[31] != y[31] &&
                     exp_result[31] != x[31]) begin
            exp_exc = EXC_OVERFLOW;
        end else if ((in_mem_op inside {MEM_LH, MEM_LHU} && off % 2 == 1) ||
                     (in_mem_op == MEM_LW && off != 0)) begin
            exp_exc = EXC_ADEL;
        end else if ((in_mem_op == MEM_SH && off % 2 == 1) ||
                     (in_mem_op == MEM_SW && off != 0)) begin
            exp_exc = EXC_ADES;
        end
        exp_bad = (exp_exc == EXC_ADEL || exp_exc == EXC_ADES) ? exp_result : '0;
        exp_req = (is_ld || exp_store) && exp_exc == EXC_NONE;
        for (k = 0; k < NUM_LANES; k++) begin
            case (in_mem_op)
                MEM_SB:  exp_wstrb[k] = (k == off);
                MEM_SH:  exp_wstrb[k] = (k == off) || (k == off + 1);
                MEM_SW:  exp_wstrb[k] = 1'b1;
                MEM_SWL: exp_wstrb[k] = (k <= off);
                MEM_SWR: exp_wstrb[k] = (k >= off);
                default: exp_wstrb[k] = 1'b0;
            endcase
            src = k;
            if (exp_wstrb[k]) begin
                case (in_mem_op)
                    MEM_SB:  src = 0;
                    MEM_SH:  src = k % 2;
                    MEM_SWL: src = 3 - off + k;
                    MEM_SWR: src = k - off;
                    default: src = k;
                endcase
            end
            exp_wdata[8*k +: 8] = in_rt_value[8*src +: 8];
        end
    endtask

    task automatic check_held();
        check_word("out_result", out_result, exp_result);
        check_exc("out_exc_code", out_exc_code, exp_exc);
        check_word("out_bad_vaddr", out_bad_vaddr, exp_bad);
        check_reg_idx("out_dest", out_dest, in_dest);
        check_mem_op("out_mem_op", out_mem_op, in_mem_op);
        if (exp_req) begin
            check_word("data_sram_addr", data_sram_addr, exp_result);
            check_bit("data_sram_wr", data_sram_wr, exp_store);
            check_strobe("data_sram_wstrb", data_sram_wstrb, exp_wstrb);
            if (exp_store) begin
                check_word("data_sram_wdata", data_sram_wdata, exp_wdata);
            end
        end
    endtask

    task automatic finish_cycle();
        @(posedge clk);
        #1;
    endtask

    // offer the instruction and return just after the edge that took it
    task automatic issue();
        in_valid = 1'b1;
        #1;
        while (!allowin) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_and_check();
        predict();
        issue();
        #1;
        check_bit("out_valid", out_valid, 1'b1);
        check_bit("data_sram_en", data_sram_en, exp_req);
        check_held();
    endtask

    task automatic set_arith(input alu_op_e a, input word_t rs, input word_t rt, input logic ofc);
        in_alu_op   = a;
        in_src1_sel = SRC1_RS;
        in_src2_sel = SRC2_RT;
        in_rs_value = rs;
        in_rt_value = rt;
        in_of_check = ofc;
        in_mem_op   = MEM_NONE;
    endtask

    // base plus offset with the low address bits set to off
    task automatic set_mem_instr(input mem_op_e m, input logic [1:0] off);
        word_t r;
        r = lcg_next();
        in_alu_op   = ALU_ADD;
        in_src1_sel = SRC1_RS;
        in_src2_sel = SRC2_IMM_SEXT;
        in_rs_value = {r[31:2], 2'b00};
        r = lcg_next();
        in_imm      = {r[15:2], off};
        in_dest     = r[20:16];
        in_rt_value = lcg_next();
        in_of_check = 1'b0;
        in_mem_op   = m;
    endtask

    task automatic test_alu();
        word_t r;
        for (int a = 0; a < 12; a++) begin
            for (int s1 = 0; s1 < 3; s1++) begin
                for (int s2 = 0; s2 < 4; s2++) begin
                    set_arith(alu_op_e'(a), lcg_next(), lcg_next(), 1'b0);
                    in_src1_sel = src1_sel_e'(s1);
                    in_src2_sel = src2_sel_e'(s2);
                    in_pc       = lcg_next();
                    r = lcg_next();
                    in_imm      = r[15:0];
                    in_dest     = r[20:16];
                    send_and_check();
                    finish_cycle();
                end
            end
        end
    endtask

    task automatic test_overflow();
        set_arith(ALU_ADD, 32'h7fffffff, 32'h00000001, 1'b1);
        send_and_check();
        check_exc("out_exc_code", out_exc_code, EXC_OVERFLOW);
        finish_cycle();
        set_arith(ALU_ADD, 32'h7fffffff, 32'h00000001, 1'b0);
        send_and_check();
        check_exc("out_exc_code", out_exc_code, EXC_NONE);
        finish_cycle();
        set_arith(ALU_SUB, 32'h80000000, 32'h00000001, 1'b1);
        send_and_check();
        check_exc("out_exc_code", out_exc_code, EXC_OVERFLOW);
        finish_cycle();
        set_arith(ALU_SUB, 32'h80000000, 32'h00000001, 1'b0);
        send_and_check();
        check_exc("out_exc_code", out_exc_code, EXC_NONE);
        finish_cycle();
        // overflow wins over the load and blocks the request
        set_mem_instr(MEM_LW, 2'b00);
        in_rs_value = 32'h7ffffffc;
        in_imm      = 16'h0004;
        in_of_check = 1'b1;
        send_and_check();
        check_exc("out_exc_code", out_exc_code, EXC_OVERFLOW);
        check_bit("data_sram_en", data_sram_en, 1'b0);
        finish_cycle();
        for (int n = 0; n < 16; n++) begin
            set_arith(n % 2 == 0 ? ALU_ADD : ALU_SUB, lcg_next(), lcg_next(), 1'b1);
            send_and_check();
            finish_cycle();
        end
    endtask

    task automatic test_stores();
        mem_op_e m;
        for (int i = int'(MEM_SB); i <= int'(MEM_SWR); i++) begin
            m = mem_op_e'(i);
            for (int off = 0; off < 4; off++) begin
                if (!((m == MEM_SH && off % 2 == 1) || (m == MEM_SW && off != 0))) begin
                    set_mem_instr(m, off[1:0]);
                    send_and_check();
                    finish_cycle();
                end
            end
        end
    endtask

    task automatic test_addr_errors();
        for (int i = int'(MEM_LB); i <= int'(MEM_SW); i++) begin
            for (int off = 0; off < 4; off++) begin
                set_mem_instr(mem_op_e'(i), off[1:0]);
                send_and_check();
                finish_cycle();
            end
        end
    endtask

    task automatic test_back_pressure();
        word_t r;
        int    wait_ok;
        int    hold;
        int    count_before;
        for (int n = 0; n < 10; n++) begin
            r = lcg_next();
            set_mem_instr(mem_op_e'(32'd1 + r % 32'd10), r[9:8]);
            wait_ok = int'(r[13:12]);
            hold = int'(r[17:16]) + 1;
            data_sram_addr_ok = 1'b0;
            next_allowin = 1'b0;
            count_before = accept_count;
            predict();
            issue();
            for (int i = 0; i < wait_ok; i++) begin
                #1;
                check_bit("out_valid", out_valid, !exp_req);
                check_bit("data_sram_en", data_sram_en, exp_req);
                check_held();
                finish_cycle();
            end
            data_sram_addr_ok = 1'b1;
            #1;
            check_bit("out_valid", out_valid, 1'b1);
            check_bit("data_sram_en", data_sram_en, exp_req);
            check_held();
            finish_cycle();
            for (int i = 0; i < hold; i++) begin
                #1;
                check_bit("out_valid", out_valid, 1'b1);
                check_bit("data_sram_en", data_sram_en, 1'b0);
                check_bit("allowin", allowin, 1'b0);
                check_held();
                finish_cycle();
            end
            next_allowin = 1'b1;
            #1;
            check_bit("out_valid", out_valid, 1'b1);
            check_bit("allowin", allowin, 1'b1);
            finish_cycle();
            if (accept_count != count_before + int'(exp_req)) begin
                $display("memory instruction accepted %0d times by the SRAM, expected %0d",
                         accept_count - count_before, int'(exp_req));
                fail_run();
            end
        end
    endtask

    initial begin
        reset             = 1'b1;
        in_valid          = 1'b0;
        in_alu_op         = ALU_ADD;
        in_src1_sel       = SRC1_RS;
        in_src2_sel       = SRC2_RT;
        in_rs_value       = '0;
        in_rt_value       = '0;
        in_pc             = '0;
        in_imm            = '0;
        in_dest           = '0;
        in_mem_op         = MEM_NONE;
        in_of_check       = 1'b0;
        next_allowin      = 1'b1;
        data_sram_addr_ok = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        check_bit("allowin", allowin, 1'b1);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("data_sram_en", data_sram_en, 1'b0);
        test_alu();
        test_overflow();
        test_stores();
        test_addr_errors();
        test_back_pressure();
        if (dut0.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- exe_stage_top.f
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/exe_op_if.sv
hw/mem_req_if.sv
hw/stage_ctrl.sv
hw/execute_unit.sv
hw/store_lane.sv
hw/mem_request.sv
hw/exe_stage_top.sv
verification/exe_stage_asserts.sv
verification/exe_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module exe_stage_tb \
    -f exe_stage_top.f -o exe_stage_sim > sim.log 2>&1 &&
    ./obj_dir/exe_stage_sim >> sim.log 2>&1 || true
grep -q "All tests passed!" sim.log && echo "simulation PASSED" && exit 0 ||
    { echo "simulation FAILED, see sim.log"; exit 1; }
